/* tests/ex_testdata.txt */
// uop sel pc rs1 rs2 imm rd_we rd_addr, then expected rd_wdata branch target mem_addr mem_wdata
// all hex, one micro-op per line
01 1 00001000 ffffffff 00000002 00000000 1 01 00000001 0 00000000 00000000 00000000
02 1 00001000 00000000 00000001 00000000 1 02 ffffffff 0 00000000 00000000 00000000
03 1 00001000 00000100 00000000 fffffff8 1 03 000000f8 0 00000000 00000000 00000000
06 2 00001000 f0f0f0f0 ff00ff00 00000000 1 04 0ff00ff0 0 00000000 00000000 00000000
08 2 00001000 12340000 00000000 00005678 1 05 12345678 0 00000000 00000000 00000000
10 1 00001000 ffffffff 00000001 00000000 1 06 00000001 0 00000000 00000000 00000000
11 1 00001000 ffffffff 00000001 00000000 1 07 00000000 0 00000000 00000000 00000000
13 1 00001000 00000005 00000000 fffffffe 1 08 00000001 0 00000000 00000000 00000000
14 1 00001000 00000000 00000000 abcde000 1 09 abcde000 0 00000000 00000000 00000000
15 1 00001000 00000000 00000000 00002000 1 0a 00003000 0 00000000 00000000 00000000
22 3 00001000 80000000 00000024 00000000 1 0b f8000000 0 00000000 00000000 00000000
25 3 00001000 fffffff0 00000000 00000002 1 0c fffffffc 0 00000000 00000000 00000000
20 3 00001000 00000003 00000021 00000000 1 0d 00000006 0 00000000 00000000 00000000
30 4 00001000 fffffffe 00000003 00000000 1 0e fffffffa 0 00000000 00000000 00000000
31 4 00001000 40000000 fffffff8 00000000 1 0f fffffffe 0 00000000 00000000 00000000
32 4 00001000 ffffffff ffffffff 00000000 1 10 ffffffff 0 00000000 00000000 00000000
33 4 00001000 ffffffff ffffffff 00000000 1 11 fffffffe 0 00000000 00000000 00000000
40 5 00001000 00000000 00000000 00000100 1 01 00001004 1 00001100 00000000 00000000
41 5 00001010 00002003 00000000 00000004 1 01 00001014 1 00002006 00000000 00000000
42 0 00001020 00000007 00000007 fffffff0 0 00 00000000 1 00001010 00000000 00000000
44 0 00001030 00000005 fffffffb 00000040 0 00 00000000 0 00000000 00000000 00000000
47 0 00001040 ffffffff 00000001 00000020 0 00 00000000 1 00001060 00000000 00000000
54 0 00001000 00008000 deadbeef fffffffc 1 12 00000000 0 00000000 00007ffc 00000000
5a 0 00001000 00008000 cafef00d 00000010 0 00 00000000 0 00000000 00008010 cafef00d
00 0 00000000 00000000 00000000 00000000 0 00 00000000 0 00000000 00000000 00000000

/* list.f */
design/ex_pkg.sv
design/ex_operand_stage.sv
design/ex_int_alu.sv
design/ex_multiplier.sv
design/ex_branch_unit.sv
design/ex_result_stage.sv
design/ex_top.sv
tests/ex_props.sv
tests/ex_tb.sv

/* tests/ex_tb.sv */
/*
 * testbench for ex_top, reads micro-ops and expected results from tests/ex_testdata.txt
 * issues them with random idle gaps and checks every result in issue order
 */
module ex_tb import ex_pkg::*; ();

    localparam int FIELDS     = 13;
    localparam int MAX_VEC    = 64;
    localparam int CLK_PERIOD = 100;
    // drive edge to the falling edge where the result is sampled
    localparam int LATENCY_T  = 3 * CLK_PERIOD + CLK_PERIOD / 2;

    typedef struct {
        int                    idx;
        time                   issued;
        uop_e                  uop;
        logic                  rd_we;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [XLEN_DEF-1:0]   rd_wdata;
        logic                  branch;
        logic [XLEN_DEF-1:0]   target;
        logic [XLEN_DEF-1:0]   mem_addr;
        logic [XLEN_DEF-1:0]   mem_wdata;
    } expect_t;

    logic                  clk;
    logic                  rst_n;
    logic                  valid;
    uop_e                  uop;
    alu_sel_e              alu_sel;
    logic [XLEN_DEF-1:0]   pc;
    logic [XLEN_DEF-1:0]   rs1;
    logic [XLEN_DEF-1:0]   rs2;
    logic [XLEN_DEF-1:0]   imm;
    logic                  rd_we;
    logic [REG_ADDR_W-1:0] rd_addr;

    logic                  valid_out;
    uop_e                  uop_out;
    logic                  rd_we_out;
    logic [REG_ADDR_W-1:0] rd_addr_out;
    logic [XLEN_DEF-1:0]   rd_wdata_out;
    logic                  branch_out;
    logic [XLEN_DEF-1:0]   branch_addr_out;
    logic [XLEN_DEF-1:0]   mem_addr_out;
    logic [XLEN_DEF-1:0]   mem_wdata_out;

    // 13 words per vector, unused entries stay unknown
    logic [XLEN_DEF-1:0] tv_mem [MAX_VEC*FIELDS];
    expect_t             exp_q[$];
    int                  n_vec;
    bit                  loaded;
    int                  pass_cnt;
    int                  fail_cnt;
    int                  err_cnt;
    integer              seed;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ex_top #(.XLEN(XLEN_DEF)) i_dut (
        .clk_i(clk), .rst_n_i(rst_n), .valid_i(valid), .uop_i(uop), .alu_sel_i(alu_sel),
        .pc_i(pc), .rs1_i(rs1), .rs2_i(rs2), .imm_i(imm), .rd_we_i(rd_we), .rd_addr_i(rd_addr),
        .valid_o(valid_out), .uop_o(uop_out), .rd_we_o(rd_we_out), .rd_addr_o(rd_addr_out),
        .rd_wdata_o(rd_wdata_out), .branch_o(branch_out), .branch_addr_o(branch_addr_out),
        .mem_addr_o(mem_addr_out), .mem_wdata_o(mem_wdata_out)
    );

    task automatic check_uop(input int idx, input uop_e got, input uop_e exp, output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("Fail %0t test %0d: uop_o %s (%h), expected %s",
                     $time, idx, got.name(), got, exp.name());
        end
    endtask

    // register write-back port
    task automatic check_rd(input int idx,
                            input logic got_we, input logic [REG_ADDR_W-1:0] got_addr,
                            input logic [XLEN_DEF-1:0] got_data,
                            input logic exp_we, input logic [REG_ADDR_W-1:0] exp_addr,
                            input logic [XLEN_DEF-1:0] exp_data, output bit ok);
        ok = (got_we === exp_we) && (got_addr === exp_addr) && (got_data === exp_data);
        if (!ok) begin
            $display("Fail %0t test %0d: rd we/addr/data %b/%0d/%h, expected %b/%0d/%h",
                     $time, idx, got_we, got_addr, got_data, exp_we, exp_addr, exp_data);
        end
    endtask

    task automatic check_branch(input int idx,
                                input logic got_flag, input logic [XLEN_DEF-1:0] got_target,
                                input logic exp_flag, input logic [XLEN_DEF-1:0] exp_target,
                                output bit ok);
        ok = (got_flag === exp_flag) && (got_target === exp_target);
        if (!ok) begin
            $display("Fail %0t test %0d: branch %b target %h, expected %b target %h",
                     $time, idx, got_flag, got_target, exp_flag, exp_target);
        end
    endtask

    task automatic check_mem(input int idx,
                             input logic [XLEN_DEF-1:0] got_addr,
                             input logic [XLEN_DEF-1:0] got_data,
                             input logic [XLEN_DEF-1:0] exp_addr,
                             input logic [XLEN_DEF-1:0] exp_data, output bit ok);
        ok = (got_addr === exp_addr) && (got_data === exp_data);
        if (!ok) begin
            $display("Fail %0t test %0d: mem addr %h data %h, expected addr %h data %h",
                     $time, idx, got_addr, got_data, exp_addr, exp_data);
        end
    endtask

    // put one vector on the DUT inputs and queue what it should produce
    task automatic issue_vector(input int i);
        int      b;
        expect_t e;
        b = i * FIELDS;
        valid   <= 1'b1;
        uop     <= uop_e'(tv_mem[b][7:0]);
        alu_sel <= alu_sel_e'(tv_mem[b+1][2:0]);
        pc      <= tv_mem[b+2];
        rs1     <= tv_mem[b+3];
        rs2     <= tv_mem[b+4];
        imm     <= tv_mem[b+5];
        rd_we   <= tv_mem[b+6][0];
        rd_addr <= tv_mem[b+7][REG_ADDR_W-1:0];
        e.idx       = i;
        e.issued    = $time;
        e.uop       = uop_e'(tv_mem[b][7:0]);
        e.rd_we     = tv_mem[b+6][0];
        e.rd_addr   = tv_mem[b+7][REG_ADDR_W-1:0];
        e.rd_wdata  = tv_mem[b+8];
        e.branch    = tv_mem[b+9][0];
        e.target    = tv_mem[b+10];
        e.mem_addr  = tv_mem[b+11];
        e.mem_wdata = tv_mem[b+12];
        exp_q.push_back(e);
    endtask

    // outputs are sampled on the falling edge, half a period after they change
    always @(negedge clk) begin : monitor
        expect_t e;
        bit      ok_uop;
        bit      ok_rd;
        bit      ok_br;
        bit      ok_mem;
        bit      ok_time;
        if (rst_n && valid_out) begin
            if (exp_q.size() == 0) begin
                $display("valid_o high at time %0t with no micro-op outstanding", $time);
                err_cnt++;
            end else begin
                e = exp_q.pop_front();
                check_uop(e.idx, uop_out, e.uop, ok_uop);
                check_rd(e.idx, rd_we_out, rd_addr_out, rd_wdata_out,
                         e.rd_we, e.rd_addr, e.rd_wdata, ok_rd);
                check_branch(e.idx, branch_out, branch_addr_out, e.branch, e.target, ok_br);
                check_mem(e.idx, mem_addr_out, mem_wdata_out, e.mem_addr, e.mem_wdata, ok_mem);
                ok_time = ($time == e.issued + LATENCY_T);
                if (!ok_time) begin
                    $display("test %0d result came at time %0t, it was due at %0t",
                             e.idx, $time, e.issued + LATENCY_T);
                end
                if (ok_uop && ok_rd && ok_br && ok_mem && ok_time) begin
                    pass_cnt++;
                    $display("test %0d %s ok", e.idx, e.uop.name());
                end else begin
                    fail_cnt++;
                    $display("test %0d %s mismatch", e.idx, e.uop.name());
                end
            end
        end else if (rst_n && (rd_we_out !== 1'b0 || branch_out !== 1'b0)) begin
            $display("rd_we_o or branch_o high without valid_o at time %0t", $time);
            err_cnt++;
        end
    end

    initial begin : driver
        int i;
        int idle;
        seed     = 32'ha84b_9fd0;
        pass_cnt = 0;
        fail_cnt = 0;
        err_cnt  = 0;
        loaded   = 1'b0;
        rst_n    = 1'b0;
        valid    = 1'b0;
        uop      = UOP_NOP;
        alu_sel  = SEL_NONE;
        pc       = '0;
        rs1      = '0;
        rs2      = '0;
        imm      = '0;
        rd_we    = 1'b0;
        rd_addr  = '0;
        $readmemh("tests/ex_testdata.txt", tv_mem);
        n_vec = 0;
        while (n_vec < MAX_VEC && !$isunknown(tv_mem[n_vec * FIELDS])) begin
            n_vec++;
        end
        loaded = 1'b1;
        if (n_vec == 0) begin
            $display("no vectors could be read from tests/ex_testdata.txt");
            err_cnt++;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (valid_out !== 1'b0 || rd_we_out !== 1'b0 || branch_out !== 1'b0) begin
            $display("valid_o, rd_we_o or branch_o not low after reset");
            err_cnt++;
        end
        @(posedge clk);
        for (i = 0; i < n_vec; i++) begin
            // 0 to 2 idle cycles, zero gives back-to-back issue
            idle = $unsigned($random(seed)) % 3;
            valid <= 1'b0;
            repeat (idle) @(posedge clk);
            issue_vector(i);
            @(posedge clk);
        end
        valid <= 1'b0;
        // drain with a bound in case results go missing
        fork
            wait (exp_q.size() == 0);
            repeat (8) @(posedge clk);
        join_any
        disable fork;
        if (exp_q.size() != 0) begin
            $display("%0d results never appeared on valid_o", exp_q.size());
            fail_cnt += exp_q.size();
        end
        // a few more cycles catch a stray valid_o
        repeat (4) @(posedge clk);
        if (i_dut.i_props.fail_count != 0) begin
            $display("%0d assertion failures in the bound checker", i_dut.i_props.fail_count);
            err_cnt += i_dut.i_props.fail_count;
        end
        $display("%0d tests passed, %0d tests failed, %0d other errors",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // bound by the worst case of 3 cycles per vector plus reset and drain
    initial begin : watchdog
        wait (loaded);
        #((n_vec * 4 + 20) * CLK_PERIOD);
        $display("timeout, the run did not end within %0d clock periods", n_vec * 4 + 20);
        $display("Regression failed");
        $finish;
    end

endmodule

/* tests/ex_props.sv */
/*
 * concurrent checks on latency, branch qualification and reset of ex_top
 * attached to every ex_top instance by the bind below the module
 */
module ex_props (
    input logic clk_i,
    input logic rst_n_i,
    input logic valid_in_i,
    input logic valid_out_i,
    input logic rd_we_out_i,
    input logic branch_out_i
);

    // failures seen so far, read by the testbench at the end of the run
    int fail_count = 0;

    // three register stages between valid_i and valid_o
    property p_latency;
        @(posedge clk_i) disable iff (!rst_n_i)
        valid_out_i == $past(valid_in_i, 3);
    endproperty

    // a redirect only comes with a valid result
    property p_branch_needs_valid;
        @(posedge clk_i) disable iff (!rst_n_i)
        branch_out_i |-> valid_out_i;
    endproperty

    // nothing can reach the outputs before a first micro-op has crossed all stages
    property p_quiet_after_reset;
        @(posedge clk_i)
        $rose(rst_n_i) |-> (!valid_out_i && !rd_we_out_i) [*3];
    endproperty

    a_latency: assert property (p_latency)
        else begin
            $error("valid_o does not follow valid_i by three cycles");
            fail_count++;
        end

    a_branch_needs_valid: assert property (p_branch_needs_valid)
        else begin
            $error("branch_o high while valid_o is low");
            fail_count++;
        end

    a_quiet_after_reset: assert property (p_quiet_after_reset)
        else begin
            $error("valid_o or rd_we_o high too early after reset");
            fail_count++;
        end

endmodule

bind ex_top ex_props i_props (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .valid_in_i(valid_i),
    .valid_out_i(valid_o),
    .rd_we_out_i(rd_we_o),
    .branch_out_i(branch_o)
);

/* design/ex_top.sv */
/*
 * integer execution stage top level, three pipeline stages with one micro-op per clock
 * result appears three clocks after issue, no stall and no back-pressure
 */
module ex_top import ex_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  uop_e                  uop_i,
    input  alu_sel_e              alu_sel_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       rs1_i,
    input  logic [XLEN-1:0]       rs2_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic                  rd_we_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    output logic                  valid_o,
    output uop_e                  uop_o,
    output logic                  rd_we_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output logic [XLEN-1:0]       rd_wdata_o,
    output logic                  branch_o,
    output logic [XLEN-1:0]       branch_addr_o,
    output logic [XLEN-1:0]       mem_addr_o,
    output logic [XLEN-1:0]       mem_wdata_o
);

    // stage 1 outputs
    logic                  s1_valid;
    uop_e                  s1_uop;
    alu_sel_e              s1_alu_sel;
    logic [XLEN-1:0]       s1_rs1;
    logic [XLEN-1:0]       s1_rs2;
    logic [XLEN-1:0]       s1_imm;
    logic                  s1_rd_we;
    logic [REG_ADDR_W-1:0] s1_rd_addr;
    logic [XLEN-1:0]       s1_pc_plus4;
    logic [XLEN-1:0]       s1_pc_imm;
    logic [XLEN-1:0]       s1_rs1_imm;
    logic                  s1_eq;
    logic                  s1_lt;
    logic                  s1_ltu;
    logic                  s1_lt_imm;
    logic                  s1_ltu_imm;

    // stage 2 outputs, sideband comes from the integer unit
    logic                  s2_valid;
    uop_e                  s2_uop;
    alu_sel_e              s2_alu_sel;
    logic                  s2_rd_we;
    logic [REG_ADDR_W-1:0] s2_rd_addr;
    logic [XLEN-1:0]       s2_int_res;
    logic [XLEN-1:0]       s2_mem_addr;
    logic [XLEN-1:0]       s2_mem_wdata;
    logic [XLEN-1:0]       s2_mul_res;
    logic [XLEN-1:0]       s2_link;
    logic                  s2_taken;
    logic [XLEN-1:0]       s2_target;

    ex_operand_stage #(.XLEN(XLEN)) i_operand (
        .clk_i, .rst_n_i, .valid_i, .uop_i, .alu_sel_i, .pc_i, .rs1_i, .rs2_i, .imm_i,
        .rd_we_i, .rd_addr_i,
        .s1_valid_o(s1_valid), .s1_uop_o(s1_uop), .s1_alu_sel_o(s1_alu_sel),
        .s1_rs1_o(s1_rs1), .s1_rs2_o(s1_rs2), .s1_imm_o(s1_imm),
        .s1_rd_we_o(s1_rd_we), .s1_rd_addr_o(s1_rd_addr),
        .s1_pc_plus4_o(s1_pc_plus4), .s1_pc_imm_o(s1_pc_imm), .s1_rs1_imm_o(s1_rs1_imm),
        .s1_eq_o(s1_eq), .s1_lt_o(s1_lt), .s1_ltu_o(s1_ltu),
        .s1_lt_imm_o(s1_lt_imm), .s1_ltu_imm_o(s1_ltu_imm)
    );

    ex_int_alu #(.XLEN(XLEN)) i_int_alu (
        .clk_i, .rst_n_i,
        .s1_valid_i(s1_valid), .s1_uop_i(s1_uop), .s1_alu_sel_i(s1_alu_sel),
        .s1_rs1_i(s1_rs1), .s1_rs2_i(s1_rs2), .s1_imm_i(s1_imm),
        .s1_rd_we_i(s1_rd_we), .s1_rd_addr_i(s1_rd_addr),
        .s1_pc_imm_i(s1_pc_imm), .s1_rs1_imm_i(s1_rs1_imm),
        .s1_lt_i(s1_lt), .s1_ltu_i(s1_ltu), .s1_lt_imm_i(s1_lt_imm), .s1_ltu_imm_i(s1_ltu_imm),
        .s2_valid_o(s2_valid), .s2_uop_o(s2_uop), .s2_alu_sel_o(s2_alu_sel),
        .s2_rd_we_o(s2_rd_we), .s2_rd_addr_o(s2_rd_addr), .s2_int_res_o(s2_int_res),
        .s2_mem_addr_o(s2_mem_addr), .s2_mem_wdata_o(s2_mem_wdata)
    );

    ex_multiplier #(.XLEN(XLEN)) i_multiplier (
        .clk_i, .rst_n_i,
        .s1_uop_i(s1_uop), .s1_rs1_i(s1_rs1), .s1_rs2_i(s1_rs2),
        .s2_mul_res_o(s2_mul_res)
    );

    ex_branch_unit #(.XLEN(XLEN)) i_branch (
        .clk_i, .rst_n_i,
        .s1_valid_i(s1_valid), .s1_uop_i(s1_uop),
        .s1_pc_plus4_i(s1_pc_plus4), .s1_pc_imm_i(s1_pc_imm), .s1_rs1_imm_i(s1_rs1_imm),
        .s1_eq_i(s1_eq), .s1_lt_i(s1_lt), .s1_ltu_i(s1_ltu),
        .s2_link_o(s2_link), .s2_taken_o(s2_taken), .s2_target_o(s2_target)
    );

    ex_result_stage #(.XLEN(XLEN)) i_result (
        .clk_i, .rst_n_i,
        .s2_valid_i(s2_valid), .s2_uop_i(s2_uop), .s2_alu_sel_i(s2_alu_sel),
        .s2_rd_we_i(s2_rd_we), .s2_rd_addr_i(s2_rd_addr),
        .s2_int_res_i(s2_int_res), .s2_mul_res_i(s2_mul_res), .s2_link_i(s2_link),
        .s2_taken_i(s2_taken), .s2_target_i(s2_target),
        .s2_mem_addr_i(s2_mem_addr), .s2_mem_wdata_i(s2_mem_wdata),
        .valid_o, .uop_o, .rd_we_o, .rd_addr_o, .rd_wdata_o,
        .branch_o, .branch_addr_o, .mem_addr_o, .mem_wdata_o
    );

endmodule

/* design/ex_result_stage.sv */
/*
 * stage 3 of the execution pipeline
 * picks the write-back value, masks the memory outputs and registers all results
 */
module ex_result_stage import ex_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  s2_valid_i,
    input  uop_e                  s2_uop_i,
    input  alu_sel_e              s2_alu_sel_i,
    input  logic                  s2_rd_we_i,
    input  logic [REG_ADDR_W-1:0] s2_rd_addr_i,
    input  logic [XLEN-1:0]       s2_int_res_i,
    input  logic [XLEN-1:0]       s2_mul_res_i,
    input  logic [XLEN-1:0]       s2_link_i,
    input  logic                  s2_taken_i,
    input  logic [XLEN-1:0]       s2_target_i,
    input  logic [XLEN-1:0]       s2_mem_addr_i,
    input  logic [XLEN-1:0]       s2_mem_wdata_i,
    output logic                  valid_o,
    output uop_e                  uop_o,
    output logic                  rd_we_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output logic [XLEN-1:0]       rd_wdata_o,
    output logic                  branch_o,
    output logic [XLEN-1:0]       branch_addr_o,
    output logic [XLEN-1:0]       mem_addr_o,
    output logic [XLEN-1:0]       mem_wdata_o
);

    logic            is_mem;
    logic            is_store;
    logic [XLEN-1:0] wdata;

    assign is_store = s2_uop_i inside {UOP_SB, UOP_SH, UOP_SW};
    assign is_mem   = is_store || (s2_uop_i inside {UOP_LB, UOP_LBU, UOP_LH, UOP_LHU, UOP_LW});

    // write-back mux by result group
    always_comb begin
        case (s2_alu_sel_i)
            SEL_ARITH, SEL_LOGIC, SEL_SHIFT: wdata = s2_int_res_i;
            SEL_MUL:  wdata = s2_mul_res_i;
            SEL_JUMP: wdata = s2_link_i;
            default:  wdata = '0;
        endcase
    end

    // empty slots present all zeros downstream
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !s2_valid_i) begin
            valid_o       <= 1'b0;
            uop_o         <= UOP_NOP;
            rd_we_o       <= 1'b0;
            rd_addr_o     <= '0;
            rd_wdata_o    <= '0;
            branch_o      <= 1'b0;
            branch_addr_o <= '0;
            mem_addr_o    <= '0;
            mem_wdata_o   <= '0;
        end else begin
            valid_o       <= 1'b1;
            uop_o         <= s2_uop_i;
            rd_we_o       <= s2_rd_we_i;
            rd_addr_o     <= s2_rd_addr_i;
            rd_wdata_o    <= wdata;
            branch_o      <= s2_taken_i;
            branch_addr_o <= s2_target_i;
            mem_addr_o    <= is_mem ? s2_mem_addr_i : '0;
            mem_wdata_o   <= is_store ? s2_mem_wdata_i : '0;
        end
    end

endmodule

/* design/ex_branch_unit.sv */
/*
 * stage 2 branch unit
 * resolves jumps and conditional branches, registers link, taken flag and target
 */
module ex_branch_unit import ex_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            s1_valid_i,
    input  uop_e            s1_uop_i,
    input  logic [XLEN-1:0] s1_pc_plus4_i,
    input  logic [XLEN-1:0] s1_pc_imm_i,
    input  logic [XLEN-1:0] s1_rs1_imm_i,
    input  logic            s1_eq_i,
    input  logic            s1_lt_i,
    input  logic            s1_ltu_i,
    output logic [XLEN-1:0] s2_link_o,
    output logic            s2_taken_o,
    output logic [XLEN-1:0] s2_target_o
);

    logic            taken;
    logic [XLEN-1:0] dest;

    always_comb begin
        taken = 1'b0;
        dest  = s1_pc_imm_i;
        case (s1_uop_i)
            UOP_JAL:  taken = 1'b1;
            // jalr target drops bit 0
            UOP_JALR: begin
                taken = 1'b1;
                dest  = {s1_rs1_imm_i[XLEN-1:1], 1'b0};
            end
            UOP_BEQ:  taken = s1_eq_i;
            UOP_BNE:  taken = !s1_eq_i;
            UOP_BLT:  taken = s1_lt_i;
            UOP_BGE:  taken = !s1_lt_i;
            UOP_BLTU: taken = s1_ltu_i;
            UOP_BGEU: taken = !s1_ltu_i;
            default:  taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s2_taken_o <= 1'b0;
        end else begin
            // an empty slot never redirects fetch
            s2_taken_o <= s1_valid_i && taken;
        end
    end

    always_ff @(posedge clk_i) begin
        s2_link_o   <= s1_pc_plus4_i;
        // not taken gives a zero target
        s2_target_o <= taken ? dest : '0;
    end

endmodule

/* design/ex_multiplier.sv */
/*
 * stage 2 multiply unit for MUL, MULH, MULHSU and MULHU
 * multiplies magnitudes and restores the sign of the double-width product
 */
module ex_multiplier import ex_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  uop_e            s1_uop_i,
    input  logic [XLEN-1:0] s1_rs1_i,
    input  logic [XLEN-1:0] s1_rs2_i,
    output logic [XLEN-1:0] s2_mul_res_o
);

    localparam int PW = 2 * XLEN;

    logic            a_neg;
    logic            b_neg;
    logic [XLEN-1:0] a_mag;
    logic [XLEN-1:0] b_mag;
    logic [PW-1:0]   prod_mag;
    logic [PW-1:0]   prod;

    // which operands count as signed for this micro-op
    always_comb begin
        a_neg = 1'b0;
        b_neg = 1'b0;
        case (s1_uop_i)
            UOP_MULH: begin
                a_neg = s1_rs1_i[XLEN-1];
                b_neg = s1_rs2_i[XLEN-1];
            end
            // rs2 is unsigned here
            UOP_MULHSU: begin
                a_neg = s1_rs1_i[XLEN-1];
            end
            default: begin
                a_neg = 1'b0;
                b_neg = 1'b0;
            end
        endcase
    end

    // most negative value maps to 2^(XLEN-1), still exact as unsigned
    assign a_mag = a_neg ? (~s1_rs1_i + 1'b1) : s1_rs1_i;
    assign b_mag = b_neg ? (~s1_rs2_i + 1'b1) : s1_rs2_i;

    assign prod_mag = PW'(a_mag) * PW'(b_mag);

    // product is negative when exactly one operand was
    assign prod = (a_neg ^ b_neg) ? (~prod_mag + 1'b1) : prod_mag;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s2_mul_res_o <= '0;
        end else if (s1_uop_i == UOP_MUL) begin
            s2_mul_res_o <= prod[XLEN-1:0];
        end else begin
            // high half for MULH, MULHSU and MULHU
            s2_mul_res_o <= prod[PW-1:XLEN];
        end
    end

endmodule

/* design/ex_int_alu.sv */
/*
 * stage 2 integer unit for arithmetic, logic, compare and shift results
 * also carries the micro-op sideband and the memory address and store data onward
 */
module ex_int_alu import ex_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  s1_valid_i,
    input  uop_e                  s1_uop_i,
    input  alu_sel_e              s1_alu_sel_i,
    input  logic [XLEN-1:0]       s1_rs1_i,
    input  logic [XLEN-1:0]       s1_rs2_i,
    input  logic [XLEN-1:0]       s1_imm_i,
    input  logic                  s1_rd_we_i,
    input  logic [REG_ADDR_W-1:0] s1_rd_addr_i,
    input  logic [XLEN-1:0]       s1_pc_imm_i,
    input  logic [XLEN-1:0]       s1_rs1_imm_i,
    input  logic                  s1_lt_i,
    input  logic                  s1_ltu_i,
    input  logic                  s1_lt_imm_i,
    input  logic                  s1_ltu_imm_i,
    output logic                  s2_valid_o,
    output uop_e                  s2_uop_o,
    output alu_sel_e              s2_alu_sel_o,
    output logic                  s2_rd_we_o,
    output logic [REG_ADDR_W-1:0] s2_rd_addr_o,
    output logic [XLEN-1:0]       s2_int_res_o,
    output logic [XLEN-1:0]       s2_mem_addr_o,
    output logic [XLEN-1:0]       s2_mem_wdata_o
);

    // shift amount uses only the low log2(XLEN) bits
    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt_reg;
    logic [SHAMT_W-1:0] shamt_imm;
    logic [XLEN-1:0]    int_res;

    assign shamt_reg = s1_rs2_i[SHAMT_W-1:0];
    assign shamt_imm = s1_imm_i[SHAMT_W-1:0];

    always_comb begin
        int_res = '0;
        case (s1_uop_i)
            UOP_ADD:   int_res = s1_rs1_i + s1_rs2_i;
            UOP_SUB:   int_res = s1_rs1_i - s1_rs2_i;
            UOP_ADDI:  int_res = s1_rs1_imm_i;
            UOP_AND:   int_res = s1_rs1_i & s1_rs2_i;
            UOP_OR:    int_res = s1_rs1_i | s1_rs2_i;
            UOP_XOR:   int_res = s1_rs1_i ^ s1_rs2_i;
            UOP_ANDI:  int_res = s1_rs1_i & s1_imm_i;
            UOP_ORI:   int_res = s1_rs1_i | s1_imm_i;
            UOP_XORI:  int_res = s1_rs1_i ^ s1_imm_i;
            // compares give 1 or 0 in the low bit
            UOP_SLT:   int_res = XLEN'(s1_lt_i);
            UOP_SLTU:  int_res = XLEN'(s1_ltu_i);
            UOP_SLTI:  int_res = XLEN'(s1_lt_imm_i);
            UOP_SLTIU: int_res = XLEN'(s1_ltu_imm_i);
            // imm already holds the shifted upper immediate
            UOP_LUI:   int_res = s1_imm_i;
            UOP_AUIPC: int_res = s1_pc_imm_i;
            UOP_SLL:   int_res = s1_rs1_i << shamt_reg;
            UOP_SRL:   int_res = s1_rs1_i >> shamt_reg;
            // arithmetic right shift fills with the sign bit
            UOP_SRA:   int_res = $signed(s1_rs1_i) >>> shamt_reg;
            UOP_SLLI:  int_res = s1_rs1_i << shamt_imm;
            UOP_SRLI:  int_res = s1_rs1_i >> shamt_imm;
            UOP_SRAI:  int_res = $signed(s1_rs1_i) >>> shamt_imm;
            default:   int_res = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s2_valid_o <= 1'b0;
            s2_rd_we_o <= 1'b0;
        end else begin
            s2_valid_o <= s1_valid_i;
            s2_rd_we_o <= s1_rd_we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        s2_uop_o       <= s1_uop_i;
        s2_alu_sel_o   <= s1_alu_sel_i;
        s2_rd_addr_o   <= s1_rd_addr_i;
        s2_int_res_o   <= int_res;
        // the result stage masks these for non-memory micro-ops
        s2_mem_addr_o  <= s1_rs1_imm_i;
        s2_mem_wdata_o <= s1_rs2_i;
    end

endmodule

/* design/ex_operand_stage.sv */
/*
 * stage 1 of the execution pipeline
 * registers the decoded micro-op together with shared sums and compare flags
 */
module ex_operand_stage import ex_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  uop_e                  uop_i,
    input  alu_sel_e              alu_sel_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       rs1_i,
    input  logic [XLEN-1:0]       rs2_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic                  rd_we_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    output logic                  s1_valid_o,
    output uop_e                  s1_uop_o,
    output alu_sel_e              s1_alu_sel_o,
    output logic [XLEN-1:0]       s1_rs1_o,
    output logic [XLEN-1:0]       s1_rs2_o,
    output logic [XLEN-1:0]       s1_imm_o,
    output logic                  s1_rd_we_o,
    output logic [REG_ADDR_W-1:0] s1_rd_addr_o,
    output logic [XLEN-1:0]       s1_pc_plus4_o,
    output logic [XLEN-1:0]       s1_pc_imm_o,
    output logic [XLEN-1:0]       s1_rs1_imm_o,
    output logic                  s1_eq_o,
    output logic                  s1_lt_o,
    output logic                  s1_ltu_o,
    output logic                  s1_lt_imm_o,
    output logic                  s1_ltu_imm_o
);

    // slot valid entering stage 1
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s1_valid_o <= 1'b0;
        end else begin
            s1_valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_uop_o     <= uop_i;
        s1_alu_sel_o <= alu_sel_i;
        s1_rs1_o     <= rs1_i;
        s1_rs2_o     <= rs2_i;
        s1_imm_o     <= imm_i;
        s1_rd_we_o   <= rd_we_i;
        s1_rd_addr_o <= rd_addr_i;
        // link value for jal and jalr
        s1_pc_plus4_o <= pc_i + XLEN'(4);
        // auipc result and pc-relative branch target
        s1_pc_imm_o <= pc_i + imm_i;
        // addi result, load/store address and jalr target
        s1_rs1_imm_o <= rs1_i + imm_i;
        // register compares serve both slt and the branch conditions
        s1_eq_o  <= (rs1_i == rs2_i);
        s1_lt_o  <= ($signed(rs1_i) < $signed(rs2_i));
        s1_ltu_o <= (rs1_i < rs2_i);
        // immediate compares for slti and sltiu
        s1_lt_imm_o  <= ($signed(rs1_i) < $signed(imm_i));
        s1_ltu_imm_o <= (rs1_i < imm_i);
    end

endmodule

/* design/ex_pkg.sv */
/*
 * shared types and constants for the three-stage integer execution pipeline
 * imported by every stage module and by the testbench
 */
package ex_pkg;

    // default data width handed to every module through XLEN
    localparam int XLEN_DEF = 32;

    // register file address width
    localparam int REG_ADDR_W = 5;

    // micro-op codes as delivered by the decoder
    // grouped by unit so a waveform shows the class at a glance
    typedef enum logic [7:0] {
        UOP_NOP    = 8'h00,
        // arithmetic and logic
        UOP_ADD    = 8'h01,
        UOP_SUB    = 8'h02,
        UOP_ADDI   = 8'h03,
        UOP_AND    = 8'h04,
        UOP_OR     = 8'h05,
        UOP_XOR    = 8'h06,
        UOP_ANDI   = 8'h07,
        UOP_ORI    = 8'h08,
        UOP_XORI   = 8'h09,
        // compares and upper immediates
        UOP_SLT    = 8'h10,
        UOP_SLTU   = 8'h11,
        UOP_SLTI   = 8'h12,
        UOP_SLTIU  = 8'h13,
        UOP_LUI    = 8'h14,
        UOP_AUIPC  = 8'h15,
        // shifts
        UOP_SLL    = 8'h20,
        UOP_SRL    = 8'h21,
        UOP_SRA    = 8'h22,
        UOP_SLLI   = 8'h23,
        UOP_SRLI   = 8'h24,
        UOP_SRAI   = 8'h25,
        // multiply
        UOP_MUL    = 8'h30,
        UOP_MULH   = 8'h31,
        UOP_MULHSU = 8'h32,
        UOP_MULHU  = 8'h33,
        // jumps and conditional branches
        UOP_JAL    = 8'h40,
        UOP_JALR   = 8'h41,
        UOP_BEQ    = 8'h42,
        UOP_BNE    = 8'h43,
        UOP_BLT    = 8'h44,
        UOP_BGE    = 8'h45,
        UOP_BLTU   = 8'h46,
        UOP_BGEU   = 8'h47,
        // loads then stores
        UOP_LB     = 8'h50,
        UOP_LBU    = 8'h51,
        UOP_LH     = 8'h52,
        UOP_LHU    = 8'h53,
        UOP_LW     = 8'h54,
        UOP_SB     = 8'h58,
        UOP_SH     = 8'h59,
        UOP_SW     = 8'h5a
    } uop_e;

    // result group, picks which unit feeds the register write-back
    typedef enum logic [2:0] {
        SEL_NONE  = 3'd0,
        SEL_ARITH = 3'd1,
        SEL_LOGIC = 3'd2,
        SEL_SHIFT = 3'd3,
        SEL_MUL   = 3'd4,
        SEL_JUMP  = 3'd5
    } alu_sel_e;

endpackage
